// ==== files.f ====
+incdir+.
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
uart_checker.sv
uart_tb.sv

// ==== uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// register block location, one word per register
`define UART_BASE_ADDR          32'hC000_0200
`define UART_STACK_OFS          32'd0
`define UART_CTRL_OFS           32'd4
`define UART_CTRL_SET_OFS       32'd8
`define UART_CTRL_CLR_OFS       32'd12
`define UART_TX_STAT_OFS        32'd16
`define UART_TX_STAT_SET_OFS    32'd20
`define UART_TX_STAT_CLR_OFS    32'd24
`define UART_RX_STAT_OFS        32'd28
`define UART_RX_STAT_SET_OFS    32'd32
`define UART_RX_STAT_CLR_OFS    32'd36

// fifo geometry, 8 entries each
`define UART_TX_ADDR_WIDTH      3
`define UART_RX_ADDR_WIDTH      3
`define UART_DATA_WIDTH         8

`define UART_BAUD_RESET         24'd3333

`endif

// ==== uart_checker.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_checker (
    input logic        clk,
    input logic        n_reset,
    input logic [31:0] haddr,
    input logic        hwrite,
    input logic [1:0]  htrans,
    input logic [31:0] hrdata,
    input logic        hready,
    input logic        hresp,
    input logic        tx,
    input logic        int_any
);

    logic stack_rd;    // address phase of a stack read

    assign stack_rd = htrans[1] && !hwrite
                   && (haddr == `UART_BASE_ADDR + `UART_STACK_OFS);

    // zero wait states and OKAY only
    bus_okay: assert property (@(posedge clk) disable iff (!n_reset) hready && !hresp)
        else $error("hready low or hresp not OKAY");

    tx_idle_after_reset: assert property (@(posedge clk) $rose(n_reset) |-> tx)
        else $error("tx not high in the first cycle after reset release");

    stack_upper_zero: assert property (@(posedge clk) disable iff (!n_reset)
        stack_rd |=> (hrdata[31:8] == 24'd0))
        else $error("stack read returned nonzero upper bits");

    int_low_in_reset: assert property (@(posedge clk) !n_reset |-> !int_any)
        else $error("int_any high during reset");

endmodule

bind uart_top uart_checker protocol_chk (
    .clk(clk), .n_reset(n_reset),
    .haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hrdata(hrdata),
    .hready(hready), .hresp(hresp), .tx(tx), .int_any(int_any)
);

// ==== uart_fifo.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_fifo #(
    parameter int addr_width = 3
) (
    input  logic                        clk,
    input  logic                        n_reset,
    input  logic                        push,
    input  logic [`UART_DATA_WIDTH-1:0] din,
    input  logic                        pop,
    output logic [`UART_DATA_WIDTH-1:0] dout,
    output logic [addr_width:0]         level,
    output logic                        full,
    output logic                        empty
);

    localparam int depth = 1 << addr_width;

    logic [`UART_DATA_WIDTH-1:0] mem [depth];
    logic [addr_width:0]         wr_ptr;     // extra msb tells full from empty
    logic [addr_width:0]         rd_ptr;
    logic                        do_push;
    logic                        do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);   // a pop frees the slot this cycle

    assign level = wr_ptr - rd_ptr;
    assign full  = level[addr_width];
    assign empty = (level == '0);
    assign dout  = mem[rd_ptr[addr_width-1:0]];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[addr_width-1:0]] <= din;
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== uart_golden.txt ====
// columns: opcode, offset or count, data, expected (hex)
// 1 write, 2 read (data = int_any), 3 push (data = step:first), 4 bad frame, 5 wait, 6 pop, 0 end
2 04 0 60000D05
2 10 0 00000200
2 1C 0 00000200
1 04 FF000010 0
2 04 0 62000010
1 0C 42000000 0
2 04 0 20000010
1 08 C0000000 0
2 04 0 60000010
1 14 00FFFF00 0
2 10 1 000B0A00
1 18 00030800 0
2 10 0 00080200
1 1C 00FFFF00 0
2 1C 1 009B9A00
1 24 00FFFF00 0
2 1C 0 00000200
1 18 00FF0000 0
2 10 0 00000200
// loopback, 8 data bits 1 stop, then 5 data bits 2 stop
3 05 00003711 0
5 10 0 5
2 1C 0 00000005
6 05 0 FF
1 04 02000010 0
2 04 0 02000010
3 04 0000A5C3 0
5 10 0 4
2 1C 0 00000004
6 04 0 1F
1 04 60000010 0
// tx overflow, the same burst then overflows rx
3 0A 00001301 0
2 10 0 00000908
1 18 00000800 0
2 10 0 00000108
5 10 0 8
2 1C 0 00000908
6 08 0 FF
1 24 00000800 0
2 1C 0 00000200
// rx underflow and interrupt
2 00 0 00000000
2 1C 0 00001200
1 20 00100000 0
2 1C 1 00101200
1 24 00001000 0
2 1C 0 00100200
1 24 00100000 0
// frame error, level stays 0
4 10 55 0
2 1C 0 00008200
1 24 00008000 0
2 1C 0 00000200
0 0 0 0

// ==== uart_pkg.sv ====
package uart_pkg;

    typedef struct packed {
        logic [2:0]  data_bits;     // 0..3 selects 5..8 bits
        logic [1:0]  rsvd_28_27;
        logic        rsvd_26;
        logic        stop_two;
        logic        rsvd_24;
        logic [23:0] baud;          // system cycles per bit
    } uart_ctrl_t;

    typedef struct packed {
        logic [7:0] rsvd;
        logic [7:0] ie;             // interrupt enables, same order as flags
        logic [7:0] flags;
        logic [7:0] level;          // live fifo fill level
    } uart_stat_t;

    // one bus word, seen as control or status depending on the address
    typedef union packed {
        uart_ctrl_t ctrl;
        uart_stat_t stat;
    } uart_reg_word_u;

    // bit positions inside ie and flags
    localparam int flag_full  = 0;
    localparam int flag_empty = 1;
    localparam int flag_over  = 3;
    localparam int flag_under = 4;
    localparam int flag_frame = 7;

endpackage

// ==== uart_regs.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_regs (
    input  logic                          clk,
    input  logic                          n_reset,
    input  logic [31:0]                   haddr,
    input  logic                          hwrite,
    input  logic [1:0]                    htrans,
    input  logic [31:0]                   hwdata,
    output logic [31:0]                   hrdata,
    output uart_pkg::uart_ctrl_t          ctrl,
    output logic                          tx_push,
    output logic [`UART_DATA_WIDTH-1:0]   tx_din,
    input  logic [`UART_TX_ADDR_WIDTH:0]  tx_level,
    input  logic                          tx_full,
    input  logic                          tx_empty,
    output logic                          rx_pop,
    input  logic [`UART_DATA_WIDTH-1:0]   rx_dout,
    input  logic [`UART_RX_ADDR_WIDTH:0]  rx_level,
    input  logic                          rx_full,
    input  logic                          rx_empty,
    input  logic                          frame_err,
    input  logic                          over_err,
    output logic                          int_any
);

    import uart_pkg::*;

    localparam logic [1:0] op_none = 2'd0;
    localparam logic [1:0] op_reg  = 2'd1;
    localparam logic [1:0] op_set  = 2'd2;
    localparam logic [1:0] op_clr  = 2'd3;

    // writable bits of each status word
    localparam logic [7:0] tx_err_mask = 8'(1 << flag_over);
    localparam logic [7:0] tx_ie_mask  = tx_err_mask | 8'(1 << flag_empty) | 8'(1 << flag_full);
    localparam logic [7:0] rx_err_mask = 8'(1 << flag_frame) | 8'(1 << flag_under)
                                       | 8'(1 << flag_over);
    localparam logic [7:0] rx_ie_mask  = rx_err_mask | 8'(1 << flag_empty) | 8'(1 << flag_full);

    logic [31:0]    haddr_reg;
    logic           wr_pend;        // write data phase in progress
    logic [31:0]    wr_ofs;
    logic [31:0]    rd_ofs;
    logic           rd_act;
    uart_reg_word_u wr_word;
    uart_ctrl_t     ctrl_q;
    logic [1:0]     ctrl_op;
    logic [1:0]     tx_op;
    logic [1:0]     rx_op;
    logic [7:0]     tx_ie;
    logic [7:0]     tx_err;
    logic [7:0]     rx_ie;
    logic [7:0]     rx_err;
    logic [7:0]     tx_flags;
    logic [7:0]     rx_flags;
    logic [7:0]     tx_event;
    logic [7:0]     rx_event;
    uart_reg_word_u tx_stat_rd;
    uart_reg_word_u rx_stat_rd;

    function automatic uart_ctrl_t ctrl_write(input logic [1:0] op, input uart_ctrl_t cur,
                                              input uart_ctrl_t wr);
        uart_ctrl_t nxt;
        logic [2:0] bits;
        nxt  = cur;
        bits = cur.data_bits;
        case (op)
            op_reg: begin
                bits         = wr.data_bits;
                nxt.stop_two = wr.stop_two;
                nxt.baud     = wr.baud;
            end
            op_set: begin
                bits         = wr.data_bits | cur.data_bits;
                nxt.stop_two = wr.stop_two | cur.stop_two;
                nxt.baud     = wr.baud | cur.baud;
            end
            op_clr: begin
                bits         = ~wr.data_bits & cur.data_bits;
                nxt.stop_two = ~wr.stop_two & cur.stop_two;
                nxt.baud     = ~wr.baud & cur.baud;
            end
            default: ;
        endcase
        nxt.data_bits = (bits > 3'd3) ? 3'd3 : bits;   // 8 bits is the widest
        return nxt;
    endfunction

    function automatic logic [7:0] stat_write(input logic [1:0] op, input logic [7:0] cur,
                                              input logic [7:0] wr, input logic [7:0] mask);
        case (op)
            op_reg:  return wr & mask;
            op_set:  return cur | (wr & mask);
            op_clr:  return cur & ~wr;
            default: return cur;
        endcase
    endfunction

    assign wr_word = hwdata;
    assign wr_ofs  = haddr_reg - `UART_BASE_ADDR;
    assign rd_ofs  = haddr - `UART_BASE_ADDR;
    assign rd_act  = htrans[1] && !hwrite;

    assign tx_push = wr_pend && (wr_ofs == `UART_STACK_OFS);
    assign tx_din  = hwdata[`UART_DATA_WIDTH-1:0] & (8'hFF >> (2'd3 - ctrl_q.data_bits[1:0]));
    assign rx_pop  = rd_act && (rd_ofs == `UART_STACK_OFS);   // pops at the address phase
    assign ctrl    = ctrl_q;

    always_comb begin
        ctrl_op = op_none;
        tx_op   = op_none;
        rx_op   = op_none;
        if (wr_pend) begin
            case (wr_ofs)
                `UART_CTRL_OFS:         ctrl_op = op_reg;
                `UART_CTRL_SET_OFS:     ctrl_op = op_set;
                `UART_CTRL_CLR_OFS:     ctrl_op = op_clr;
                `UART_TX_STAT_OFS:      tx_op   = op_reg;
                `UART_TX_STAT_SET_OFS:  tx_op   = op_set;
                `UART_TX_STAT_CLR_OFS:  tx_op   = op_clr;
                `UART_RX_STAT_OFS:      rx_op   = op_reg;
                `UART_RX_STAT_SET_OFS:  rx_op   = op_set;
                `UART_RX_STAT_CLR_OFS:  rx_op   = op_clr;
                default: ;
            endcase
        end
    end

    // live flags merged over the sticky ones
    always_comb begin
        tx_flags                  = tx_err;
        tx_flags[flag_full]       = tx_full;
        tx_flags[flag_empty]      = tx_empty;
        rx_flags                  = rx_err;
        rx_flags[flag_full]       = rx_full;
        rx_flags[flag_empty]      = rx_empty;
        tx_event                  = '0;
        tx_event[flag_over]       = tx_push && tx_full;
        rx_event                  = '0;
        rx_event[flag_over]       = over_err;
        rx_event[flag_frame]      = frame_err;
        rx_event[flag_under]      = rx_pop && rx_empty;
        tx_stat_rd                = '0;
        tx_stat_rd.stat.ie        = tx_ie;
        tx_stat_rd.stat.flags     = tx_flags;
        tx_stat_rd.stat.level     = 8'(tx_level);
        rx_stat_rd                = '0;
        rx_stat_rd.stat.ie        = rx_ie;
        rx_stat_rd.stat.flags     = rx_flags;
        rx_stat_rd.stat.level     = 8'(rx_level);
    end

    assign int_any = |(tx_ie & tx_flags) || |(rx_ie & rx_flags);

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            haddr_reg <= '0;
            wr_pend   <= 1'b0;
            ctrl_q    <= '{data_bits: 3'd3, baud: `UART_BAUD_RESET, default: '0};
            tx_ie     <= '0;
            tx_err    <= '0;
            rx_ie     <= '0;
            rx_err    <= '0;
            hrdata    <= '0;
        end else begin
            haddr_reg <= haddr;
            wr_pend   <= htrans[1] && hwrite;
            ctrl_q    <= ctrl_write(ctrl_op, ctrl_q, wr_word.ctrl);
            tx_ie     <= stat_write(tx_op, tx_ie, wr_word.stat.ie, tx_ie_mask);
            tx_err    <= stat_write(tx_op, tx_err, wr_word.stat.flags, tx_err_mask) | tx_event;
            rx_ie     <= stat_write(rx_op, rx_ie, wr_word.stat.ie, rx_ie_mask);
            rx_err    <= stat_write(rx_op, rx_err, wr_word.stat.flags, rx_err_mask) | rx_event;
            if (rd_act) begin
                case (rd_ofs)
                    `UART_STACK_OFS:
                        hrdata <= rx_empty ? '0 : 32'(rx_dout);
                    `UART_CTRL_OFS, `UART_CTRL_SET_OFS, `UART_CTRL_CLR_OFS:
                        hrdata <= ctrl_q;
                    `UART_TX_STAT_OFS, `UART_TX_STAT_SET_OFS, `UART_TX_STAT_CLR_OFS:
                        hrdata <= tx_stat_rd;
                    `UART_RX_STAT_OFS, `UART_RX_STAT_SET_OFS, `UART_RX_STAT_CLR_OFS:
                        hrdata <= rx_stat_rd;
                    default:
                        hrdata <= '0;
                endcase
            end
        end
    end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_rx (
    input  logic                        clk,
    input  logic                        n_reset,
    input  uart_pkg::uart_ctrl_t        ctrl,
    input  logic                        rx,
    input  logic                        fifo_full,
    output logic                        rx_push,
    output logic [`UART_DATA_WIDTH-1:0] rx_din,
    output logic                        frame_err,
    output logic                        over_err
);

    localparam logic [1:0] s_idle  = 2'd0;
    localparam logic [1:0] s_start = 2'd1;
    localparam logic [1:0] s_data  = 2'd2;
    localparam logic [1:0] s_stop  = 2'd3;

    logic                        rx_meta;
    logic                        rx_sync;
    logic [1:0]                  state;
    logic [23:0]                 baud_cnt;
    logic [2:0]                  bit_cnt;
    logic [2:0]                  last_bit;
    logic [`UART_DATA_WIDTH-1:0] shreg;
    logic                        bit_end;
    logic                        half_end;

    assign bit_end  = baud_cnt >= ctrl.baud - 24'd1;
    assign half_end = baud_cnt >= (ctrl.baud >> 1);
    assign last_bit = {1'b0, ctrl.data_bits[1:0]} + 3'd4;

    // two flop synchronizer, idles high
    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            state     <= s_idle;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            shreg     <= '0;
            rx_din    <= '0;
            rx_push   <= 1'b0;
            frame_err <= 1'b0;
            over_err  <= 1'b0;
        end else begin
            rx_push   <= 1'b0;        // single cycle strobes
            frame_err <= 1'b0;
            over_err  <= 1'b0;
            baud_cnt  <= bit_end ? '0 : baud_cnt + 24'd1;
            case (state)
                s_idle: begin
                    baud_cnt <= '0;
                    if (!rx_sync)
                        state <= s_start;
                end
                s_start: begin
                    if (half_end) begin      // now at mid start bit
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? s_idle : s_data;   // glitch, not a start
                    end
                end
                s_data: begin
                    if (bit_end) begin
                        shreg <= {rx_sync, shreg[`UART_DATA_WIDTH-1:1]};
                        if (bit_cnt == last_bit)
                            state <= s_stop;
                        else
                            bit_cnt <= bit_cnt + 3'd1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        rx_din <= shreg >> (2'd3 - ctrl.data_bits[1:0]);  // right align
                        if (!rx_sync)
                            frame_err <= 1'b1;
                        else if (fifo_full)
                            over_err <= 1'b1;
                        else
                            rx_push <= 1'b1;
                        state <= s_idle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== uart_tb.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tb;

    import uart_pkg::*;

    localparam int max_words  = 256;      // four words per golden line
    localparam int poll_limit = 5000;
    localparam int idle_limit = 100000;

    logic        clk;
    logic        n_reset;
    logic [31:0] haddr;
    logic        hwrite;
    logic [1:0]  htrans;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic        tx;
    logic        rx;
    logic        int_any;

    logic        line_forced;             // serial driver owns rx
    logic        forced_level;
    logic [31:0] golden [max_words];
    logic [7:0]  pat_first;               // pattern of the last push burst
    logic [7:0]  pat_step;

    uart_top uut (
        .clk(clk), .n_reset(n_reset),
        .haddr(haddr), .hwrite(hwrite), .htrans(htrans),
        .hwdata(hwdata), .hrdata(hrdata),
        .hready(hready), .hresp(hresp),
        .tx(tx), .rx(rx), .int_any(int_any)
    );

    always #10 clk = ~clk;

    // loopback from tx unless a bad frame is being driven
    always @(posedge clk) begin
        rx <= line_forced ? forced_level : tx;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic logic [`UART_DATA_WIDTH-1:0] pattern_word(input int k);
        return pat_first + 8'(k) * pat_step;
    endfunction

    task automatic check_reg(input uart_reg_word_u got, input uart_reg_word_u exp,
                             input logic [31:0] ofs);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: offset 0x%0h read 0x%08h, expected 0x%08h",
                                $time, ofs, got, exp));
    endtask

    task automatic check_data(input logic [`UART_DATA_WIDTH-1:0] got,
                              input logic [`UART_DATA_WIDTH-1:0] exp, input int index);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: stack word %0d is 0x%02h, expected 0x%02h",
                                $time, index, got, exp));
    endtask

    task automatic check_int(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH at %0t: int_any is %b, expected %b",
                                $time, got, exp));
    endtask

    task automatic bus_write(input logic [31:0] ofs, input logic [31:0] data);
        @(posedge clk);
        haddr  <= `UART_BASE_ADDR + ofs;
        hwrite <= 1'b1;
        htrans <= 2'b10;                  // nonseq
        @(posedge clk);
        hwdata <= data;
        hwrite <= 1'b0;
        htrans <= 2'b00;
        @(posedge clk);                   // write lands at end of data phase
    endtask

    task automatic bus_read(input logic [31:0] ofs, output logic [31:0] data);
        @(posedge clk);
        haddr  <= `UART_BASE_ADDR + ofs;
        hwrite <= 1'b0;
        htrans <= 2'b10;
        @(posedge clk);
        htrans <= 2'b00;
        @(negedge clk);                   // middle of the data phase
        data = hrdata;
    endtask

    task automatic push_words(input int count);
        int k;
        for (k = 0; k < count; k++)
            bus_write(`UART_STACK_OFS, 32'(pattern_word(k)));
    endtask

    // idle means tx high for longer than any frame stays high
    task automatic wait_line_idle(input int bit_cycles);
        int high_run;
        int cycles;
        high_run = 0;
        cycles   = 0;
        while (high_run < 12 * bit_cycles) begin
            @(negedge clk);
            cycles++;
            if (cycles > idle_limit)
                abort_run("timeout waiting for the serial line to go idle");
            high_run = (tx === 1'b1) ? high_run + 1 : 0;
        end
    endtask

    task automatic wait_rx_level(input int bit_cycles, input logic [7:0] exp_level);
        logic [31:0]    word;
        uart_reg_word_u stat;
        int             polls;
        polls = 0;
        bus_read(`UART_RX_STAT_OFS, word);
        stat = word;
        while (stat.stat.level != exp_level) begin
            polls++;
            if (polls > poll_limit)
                abort_run($sformatf("timeout waiting for the RX level to reach %0d",
                                    exp_level));
            bus_read(`UART_RX_STAT_OFS, word);
            stat = word;
        end
        wait_line_idle(bit_cycles);       // lets a trailing frame finish
    endtask

    task automatic drive_bit(input logic level, input int cycles);
        forced_level <= level;
        repeat (cycles) @(posedge clk);
    endtask

    // 8 data bits lsb first, stop bit held low
    task automatic send_bad_frame(input int bit_cycles, input logic [7:0] data);
        int i;
        wait_line_idle(bit_cycles);
        @(posedge clk);
        line_forced <= 1'b1;
        drive_bit(1'b0, bit_cycles);
        for (i = 0; i < 8; i++)
            drive_bit(data[i], bit_cycles);
        drive_bit(1'b0, bit_cycles);
        drive_bit(1'b1, 2 * bit_cycles);
        line_forced <= 1'b0;
    endtask

    task automatic pop_and_compare(input int count, input logic [7:0] mask);
        logic [31:0] word;
        int          k;
        for (k = 0; k < count; k++) begin
            bus_read(`UART_STACK_OFS, word);
            check_data(word[`UART_DATA_WIDTH-1:0], pattern_word(k) & mask, k);
        end
    endtask

    initial begin
        int          idx;
        logic [31:0] op;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] word;
        clk          = 1'b0;
        n_reset     <= 1'b0;
        haddr        = '0;
        hwrite       = 1'b0;
        htrans       = 2'b00;
        hwdata       = '0;
        rx           = 1'b1;
        line_forced  = 1'b0;
        forced_level = 1'b1;
        pat_first    = '0;
        pat_step     = '0;
        for (idx = 0; idx < max_words; idx++)
            golden[idx] = '0;
        $readmemh("uart_golden.txt", golden);
        if (golden[0] === 32'd0)
            abort_run("golden file is missing or holds no operations");

        repeat (5) @(posedge clk);
        n_reset <= 1'b1;

        idx = 0;
        op  = golden[0];
        while (op !== 32'd0) begin
            if (idx + 4 > max_words)
                abort_run("golden file has no end marker");
            arg     = golden[idx + 1];
            data    = golden[idx + 2];
            exp_val = golden[idx + 3];
            case (op)
                32'd1: bus_write(arg, data);
                32'd2: begin
                    bus_read(arg, word);
                    check_reg(word, exp_val, arg);
                    check_int(int_any, data[0]);   // data column holds the int level
                end
                32'd3: begin
                    pat_first = data[7:0];
                    pat_step  = data[15:8];
                    push_words(arg);
                end
                32'd4: send_bad_frame(arg, data[7:0]);
                32'd5: wait_rx_level(arg, exp_val[7:0]);
                32'd6: pop_and_compare(arg, exp_val[7:0]);
                default:
                    abort_run($sformatf("unknown opcode %0h on golden line %0d",
                                        op, idx / 4 + 1));
            endcase
            idx += 4;
            op   = (idx < max_words) ? golden[idx] : 32'd0;
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_top (
    input  logic        clk,
    input  logic        n_reset,
    input  logic [31:0] haddr,
    input  logic        hwrite,
    input  logic [1:0]  htrans,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,
    output logic        tx,
    input  logic        rx,
    output logic        int_any
);

    import uart_pkg::*;

    uart_ctrl_t                   ctrl;
    logic                         tx_push;
    logic                         tx_pop;
    logic [`UART_DATA_WIDTH-1:0]  tx_din;
    logic [`UART_DATA_WIDTH-1:0]  tx_dout;
    logic [`UART_TX_ADDR_WIDTH:0] tx_level;
    logic                         tx_full;
    logic                         tx_empty;
    logic                         rx_push;
    logic                         rx_pop;
    logic [`UART_DATA_WIDTH-1:0]  rx_din;
    logic [`UART_DATA_WIDTH-1:0]  rx_dout;
    logic [`UART_RX_ADDR_WIDTH:0] rx_level;
    logic                         rx_full;
    logic                         rx_empty;
    logic                         frame_err;
    logic                         over_err;

    // zero wait state slave, never errors
    assign hready = 1'b1;
    assign hresp  = 1'b0;

    uart_regs regs (
        .clk(clk), .n_reset(n_reset),
        .haddr(haddr), .hwrite(hwrite), .htrans(htrans),
        .hwdata(hwdata), .hrdata(hrdata),
        .ctrl(ctrl),
        .tx_push(tx_push), .tx_din(tx_din),
        .tx_level(tx_level), .tx_full(tx_full), .tx_empty(tx_empty),
        .rx_pop(rx_pop), .rx_dout(rx_dout),
        .rx_level(rx_level), .rx_full(rx_full), .rx_empty(rx_empty),
        .frame_err(frame_err), .over_err(over_err),
        .int_any(int_any)
    );

    uart_fifo #(.addr_width(`UART_TX_ADDR_WIDTH)) tx_fifo (
        .clk(clk), .n_reset(n_reset),
        .push(tx_push), .din(tx_din),
        .pop(tx_pop), .dout(tx_dout),
        .level(tx_level), .full(tx_full), .empty(tx_empty)
    );

    uart_fifo #(.addr_width(`UART_RX_ADDR_WIDTH)) rx_fifo (
        .clk(clk), .n_reset(n_reset),
        .push(rx_push), .din(rx_din),
        .pop(rx_pop), .dout(rx_dout),
        .level(rx_level), .full(rx_full), .empty(rx_empty)
    );

    uart_tx transmitter (
        .clk(clk), .n_reset(n_reset),
        .ctrl(ctrl),
        .fifo_empty(tx_empty), .fifo_dout(tx_dout), .fifo_pop(tx_pop),
        .tx(tx)
    );

    uart_rx receiver (
        .clk(clk), .n_reset(n_reset),
        .ctrl(ctrl),
        .rx(rx), .fifo_full(rx_full),
        .rx_push(rx_push), .rx_din(rx_din),
        .frame_err(frame_err), .over_err(over_err)
    );

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tx (
    input  logic                        clk,
    input  logic                        n_reset,
    input  uart_pkg::uart_ctrl_t        ctrl,
    input  logic                        fifo_empty,
    input  logic [`UART_DATA_WIDTH-1:0] fifo_dout,
    output logic                        fifo_pop,
    output logic                        tx
);

    localparam logic [1:0] s_idle  = 2'd0;
    localparam logic [1:0] s_start = 2'd1;
    localparam logic [1:0] s_data  = 2'd2;
    localparam logic [1:0] s_stop  = 2'd3;

    logic [1:0]                  state;
    logic [23:0]                 baud_cnt;
    logic [2:0]                  bit_cnt;    // data bit index, then stop bit index
    logic [2:0]                  last_bit;
    logic [`UART_DATA_WIDTH-1:0] shreg;
    logic                        bit_end;

    assign fifo_pop = (state == s_idle) && !fifo_empty;
    assign bit_end  = baud_cnt >= ctrl.baud - 24'd1;
    assign last_bit = {1'b0, ctrl.data_bits[1:0]} + 3'd4;   // 5 bits -> index 4

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            state    <= s_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            tx       <= 1'b1;
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 24'd1;
            case (state)
                s_idle: begin
                    baud_cnt <= '0;
                    if (fifo_pop) begin
                        shreg <= fifo_dout;
                        tx    <= 1'b0;          // start bit begins right away
                        state <= s_start;
                    end
                end
                s_start: begin
                    if (bit_end) begin
                        tx      <= shreg[0];
                        bit_cnt <= '0;
                        state   <= s_data;
                    end
                end
                s_data: begin
                    if (bit_end) begin
                        if (bit_cnt == last_bit) begin
                            tx      <= 1'b1;
                            bit_cnt <= '0;
                            state   <= s_stop;
                        end else begin
                            tx      <= shreg[1];   // lsb first
                            shreg   <= shreg >> 1;
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        if (ctrl.stop_two && bit_cnt == 3'd0)
                            bit_cnt <= 3'd1;       // second stop bit
                        else
                            state <= s_idle;
                    end
                end
            endcase
        end
    end

endmodule
